/* pfb_consts.svh */
`ifndef PFB_CONSTS_SVH
`define PFB_CONSTS_SVH

`default_nettype none

// sample and partial sum width, sums wrap in two's complement
`define PFB_WIDTH 16

// coefficient width, the fixed rule only spans -3..3
`define PFB_COEFF_WID 8

// frame length in cycles
// must stay a power of two so the phase counters wrap on their own
`define PFB_FFT_LEN 8

// accepted samples per frame (decimation factor)
`define PFB_DEC_FAC 6

// phase counter value right after reset
`define PFB_SRT_PHA 0

// number of tap elements in the chain
`define PFB_PTAPS 3

`default_nettype wire

`endif

/* pfb_pkg.sv */
`include "pfb_consts.svh"
`default_nettype none

package pfb_pkg;

  // samples and partial sums share one word type
  typedef logic signed [`PFB_WIDTH-1:0] sample_t;

  // filter coefficient
  typedef logic signed [`PFB_COEFF_WID-1:0] coeff_t;

  // frame phase, also used for the per-tap coefficient counter
  typedef logic [$clog2(`PFB_FFT_LEN)-1:0] phase_t;

  // everything one tap hands to the next
  typedef struct packed {
    logic    vld;   // sample valid, travels with the sum
    sample_t data;  // forwarded sample for the next tap
    sample_t sum;   // running partial sum
  } pe_link_t;

endpackage

`default_nettype wire

/* delay_buf.sv */
`timescale 1ns/1ps
`default_nettype none

// fixed-depth delay line, DEPTH enabled cycles from din to dout
module delay_buf #(
  parameter type T     = logic,  // payload type
  parameter int  DEPTH = 1       // stages, at least one
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic en,     // stages only shift while high
  input  wire T     din,
  output T          dout
);

  T sr [DEPTH];  // sr[0] is the newest entry

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        sr[i] <= '0;  // line starts out empty (zero)
      end
    end else if (en) begin
      sr[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        sr[i] <= sr[i-1];  // move everything one stage along
      end
    end
    // en low leaves every stage as it was
  end

  // oldest entry
  assign dout = sr[DEPTH-1];

endmodule

`default_nettype wire

/* pfb_pe.sv */
`timescale 1ns/1ps
`include "pfb_consts.svh"
`default_nettype none

// one polyphase tap, multiply-add plus the delay lines that feed the next tap
module pfb_pe #(
  parameter int TAP_IDX = 0  // position in the chain, picks the coefficient slice
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              en,
  input  wire pfb_pkg::pe_link_t link_in,
  output pfb_pkg::pe_link_t      link_out
);

  import pfb_pkg::*;

  localparam int FFT_LEN    = `PFB_FFT_LEN;
  localparam int DEC_FAC    = `PFB_DEC_FAC;
  localparam int LOOP_DEPTH = FFT_LEN - DEC_FAC;  // samples come back after the idle phases
  localparam int PROD_WID   = $bits(sample_t) + $bits(coeff_t);  // full product width

  // coefficient rule for this tap, values -3..3
  function automatic coeff_t coeff_rule(input int c);
    int idx;
    idx = TAP_IDX * FFT_LEN + c;
    return coeff_t'((idx % 7) - 3);
  endfunction

  coeff_t coeff_tab [FFT_LEN];  // constant table, one entry per phase
  phase_t coeff_ctr;            // walks the table backwards
  coeff_t h;                    // coefficient in use this cycle

  sample_t                       a;         // operand, new sample or looped copy
  logic signed [PROD_WID-1:0]    prod;      // a*h before truncation
  sample_t                       mac;       // sum_in + a*h
  sample_t                       loop_out;  // loop delay output
  sample_t                       data_out;  // forwarded sample
  sample_t                       sum_out;   // delayed partial sum
  logic                          vld_out;   // delayed sample valid

  // table is filled at elaboration
  for (genvar c = 0; c < FFT_LEN; c++) begin : g_coeff
    assign coeff_tab[c] = coeff_rule(c);
  end

  // counter counts down and wraps on its own (power of two length)
  always_ff @(posedge clk) begin
    if (rst) begin
      coeff_ctr <= '0;
    end else if (en) begin
      coeff_ctr <= coeff_ctr - 1'b1;
    end
  end

  assign h = coeff_tab[coeff_ctr];

  // fresh sample when one arrives, otherwise reuse from the loop line
  always_comb begin
    if (link_in.vld) begin
      a = link_in.data;
    end else begin
      a = loop_out;
    end
  end

  assign prod = a * h;                               // signed, both sides extended
  assign mac  = link_in.sum + sample_t'(prod);       // wraps at sample width

  // operand recirculation, also the source for the forwarded data
  delay_buf #(
    .T     (sample_t),
    .DEPTH (LOOP_DEPTH)
  ) loopbuf (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .din  (a),
    .dout (loop_out)
  );

  // looped samples go on to the next tap two frames later
  delay_buf #(
    .T     (sample_t),
    .DEPTH (2 * FFT_LEN)
  ) databuf (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .din  (loop_out),
    .dout (data_out)
  );

  delay_buf #(
    .T     (sample_t),
    .DEPTH (FFT_LEN)  // one frame per tap
  ) sumbuf (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .din  (mac),
    .dout (sum_out)
  );

  // valid keeps pace with the sum
  delay_buf #(
    .T     (logic),
    .DEPTH (FFT_LEN)
  ) validbuf (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .din  (link_in.vld),
    .dout (vld_out)
  );

  assign link_out = '{vld: vld_out, data: data_out, sum: sum_out};

endmodule

`default_nettype wire

/* ospfb.sv */
`timescale 1ns/1ps
`include "pfb_consts.svh"
`default_nettype none

// oversampled polyphase filter bank front end
// phase counter gates the input, a systolic chain of taps forms the sums
module ospfb (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             en,        // freezes the whole datapath when low
  input  wire pfb_pkg::sample_t s_tdata,
  input  wire logic             s_tvalid,
  output logic                  s_tready,
  output pfb_pkg::sample_t      m_tdata,   // final partial sum
  output logic                  m_tvalid   // no ready, the sink takes every word
);

  import pfb_pkg::*;

  localparam int PTAPS   = `PFB_PTAPS;
  localparam int DEC_FAC = `PFB_DEC_FAC;

  // starting phase decides which branch sees the first sample
  localparam phase_t SRT_PHA = phase_t'(`PFB_SRT_PHA);

  phase_t   phase;   // position inside the current frame
  logic     accept;  // sample enters the chain this cycle
  pe_link_t links [PTAPS+1];  // links[0] is built here, links[PTAPS] is the output

  // frame phase, counts enabled cycles only
  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= SRT_PHA;
    end else if (en) begin
      phase <= phase + 1'b1;  // wraps at FFT_LEN
    end
  end

  // ready for the first DEC_FAC phases, idle for the rest of the frame
  assign s_tready = (phase < DEC_FAC);

  assign accept = s_tvalid & s_tready & en;

  // head of the chain, partial sum starts at zero
  assign links[0] = '{vld: accept, data: s_tdata, sum: '0};

  // taps chained point to point
  for (genvar p = 0; p < PTAPS; p++) begin : g_tap
    pfb_pe #(
      .TAP_IDX (p)
    ) u_pe (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .link_in  (links[p]),
      .link_out (links[p+1])
    );
  end

  // last tap's sum is the filter output
  assign m_tvalid = links[PTAPS].vld;
  assign m_tdata  = links[PTAPS].sum;

endmodule

`default_nettype wire

/* ospfb_asserts.sv */
`timescale 1ns/1ps
`include "pfb_consts.svh"
`default_nettype none

// protocol and freeze checks on the filter bank top level
module ospfb_asserts (
  input wire logic             clk,
  input wire logic             rst,
  input wire logic             en,
  input wire logic             s_tready,
  input wire pfb_pkg::sample_t m_tdata,
  input wire logic             m_tvalid
);

  import pfb_pkg::*;

  localparam int FFT_LEN = `PFB_FFT_LEN;
  localparam int DEC_FAC = `PFB_DEC_FAC;
  localparam int SRT_PHA = `PFB_SRT_PHA;

  int frame_pos;  // own count of enabled cycles inside the frame

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_pos <= SRT_PHA;
    end else if (en) begin
      frame_pos <= (frame_pos + 1) % FFT_LEN;  // wraps at the frame end
    end
  end

  // output strobe must be a clean 0/1 once out of reset
  a_vld_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(m_tvalid))
    else $error("m_tvalid is unknown outside reset");

  // idle part of the frame never offers ready
  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    (frame_pos >= DEC_FAC) |-> !s_tready)
    else $error("s_tready high in an idle phase");

  // frozen datapath holds the output word and strobe
  a_freeze: assert property (@(posedge clk) disable iff (rst)
    !en |=> ($stable(m_tdata) && $stable(m_tvalid)))
    else $error("output changed while en was low");

endmodule

bind ospfb ospfb_asserts u_asserts (
  .clk(clk), .rst(rst), .en(en),
  .s_tready(s_tready), .m_tdata(m_tdata), .m_tvalid(m_tvalid)
);

`default_nettype wire

/* tb_ospfb.sv */
`timescale 1ns/1ps
`include "pfb_consts.svh"
`default_nettype none

module tb_ospfb;

  import pfb_pkg::*;

  localparam int FFT_LEN  = `PFB_FFT_LEN;
  localparam int DEC_FAC  = `PFB_DEC_FAC;
  localparam int SRT_PHA  = `PFB_SRT_PHA;
  localparam int PTAPS    = `PFB_PTAPS;
  localparam int LOOP_D   = FFT_LEN - DEC_FAC;  // idle phases per frame
  localparam int DATA_D   = 2 * FFT_LEN;
  localparam int HALF_PER = 20;                 // 40 ns period
  localparam logic [31:0] SEED = 32'h7150fcc6;
  localparam int RAND_CYCLES   = 400;
  localparam int FREEZE_CYCLES = 300;
  localparam int READY_TIMEOUT = 4 * FFT_LEN;
  localparam int VALID_TIMEOUT = 4 * PTAPS * FFT_LEN;

  logic    clk;
  logic    rst;
  logic    en;
  sample_t s_tdata;
  logic    s_tvalid;
  logic    s_tready;
  sample_t m_tdata;
  logic    m_tvalid;

  logic [31:0] lfsr;     // random state
  int          cyc;      // enabled cycles since reset

  // model of each tap, index 0 is the newest entry of a line
  sample_t loop_q [PTAPS][LOOP_D];
  sample_t data_q [PTAPS][DATA_D];
  sample_t sum_q  [PTAPS][FFT_LEN];
  logic    vld_q  [PTAPS][FFT_LEN];
  int      cc_q   [PTAPS];  // coefficient counters
  int      ph_q;            // frame phase

  ospfb dut (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PER;
      clk = ~clk;
    end
  end

  // x^32 + x^22 + x^2 + x + 1, shifts left
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH time=%0t m_tvalid expected=%b actual=%b",
                         $time, exp, act));
    end
  endtask

  task automatic check_ready(input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH time=%0t s_tready expected=%b actual=%b",
                         $time, exp, act));
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      fail_now($sformatf("MISMATCH time=%0t latency expected=%0d actual=%0d",
                         $time, exp, act));
    end
  endtask

  // coefficient of tap p at counter value c
  function automatic int ref_coeff(input int p, input int c);
    return ((p * FFT_LEN + c) % 7) - 3;
  endfunction

  function automatic void model_reset();
    for (int p = 0; p < PTAPS; p++) begin
      for (int i = 0; i < LOOP_D; i++) loop_q[p][i] = '0;
      for (int i = 0; i < DATA_D; i++) data_q[p][i] = '0;
      for (int i = 0; i < FFT_LEN; i++) begin
        sum_q[p][i] = '0;
        vld_q[p][i] = 1'b0;
      end
      cc_q[p] = 0;
    end
    ph_q = SRT_PHA;
  endfunction

  // one enabled clock edge of the whole chain
  function automatic void model_step(input logic acc, input sample_t din);
    logic    in_vld  [PTAPS];
    sample_t in_data [PTAPS];
    sample_t in_sum  [PTAPS];
    sample_t opnd    [PTAPS];
    sample_t mac     [PTAPS];
    int      coef;
    in_vld[0]  = acc;
    in_data[0] = din;
    in_sum[0]  = '0;  // chain starts from zero
    for (int p = 1; p < PTAPS; p++) begin
      in_vld[p]  = vld_q[p-1][FFT_LEN-1];  // links use the state before the edge
      in_data[p] = data_q[p-1][DATA_D-1];
      in_sum[p]  = sum_q[p-1][FFT_LEN-1];
    end
    for (int p = 0; p < PTAPS; p++) begin
      coef    = ref_coeff(p, cc_q[p]);
      opnd[p] = in_vld[p] ? in_data[p] : loop_q[p][LOOP_D-1];  // reuse when idle
      mac[p]  = sample_t'(int'(in_sum[p]) + int'(opnd[p]) * coef);  // wraps at 16 bits
    end
    for (int p = 0; p < PTAPS; p++) begin
      for (int i = DATA_D-1; i > 0; i--) data_q[p][i] = data_q[p][i-1];
      data_q[p][0] = loop_q[p][LOOP_D-1];  // loop tail before it shifts
      for (int i = LOOP_D-1; i > 0; i--) loop_q[p][i] = loop_q[p][i-1];
      loop_q[p][0] = opnd[p];
      for (int i = FFT_LEN-1; i > 0; i--) begin
        sum_q[p][i] = sum_q[p][i-1];
        vld_q[p][i] = vld_q[p][i-1];
      end
      sum_q[p][0] = mac[p];
      vld_q[p][0] = in_vld[p];
      cc_q[p]     = (cc_q[p] + FFT_LEN - 1) % FFT_LEN;  // counts down
    end
    ph_q = (ph_q + 1) % FFT_LEN;
  endfunction

  // model follows every edge, DUT checked once its registers have moved
  always @(posedge clk) begin
    if (rst) begin
      model_reset();
      cyc = 0;
    end else if (en) begin
      model_step(s_tvalid && (ph_q < DEC_FAC), s_tdata);
      cyc++;
    end
    #1;
    check_valid(vld_q[PTAPS-1][FFT_LEN-1], m_tvalid);
    check_sample("m_tdata", sum_q[PTAPS-1][FFT_LEN-1], m_tdata);
    check_ready(ph_q < DEC_FAC, s_tready);
  end

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (s_tready !== 1'b1) begin
      if (n >= limit) begin
        fail_now("input did not become ready within the timeout");
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_out_valid(input int limit);
    int n;
    n = 0;
    while (m_tvalid !== 1'b1) begin
      if (n >= limit) begin
        fail_now("output valid did not appear within the timeout");
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    int          acc_cyc;
    int          burst;
    int          low_cnt;
    rst      = 1'b1;
    en       = 1'b1;
    s_tvalid = 1'b0;
    s_tdata  = '0;
    lfsr     = SEED;
    cyc      = 0;
    repeat (2) @(posedge clk);  // two reset cycles
    @(negedge clk);
    rst = 1'b0;

    // readiness over three frames
    for (int f = 0; f < 3; f++) begin
      for (int k = 0; k < FFT_LEN; k++) begin
        check_ready(((SRT_PHA + k) % FFT_LEN) < DEC_FAC, s_tready);
        @(negedge clk);
      end
    end

    // single unit sample
    wait_ready(READY_TIMEOUT);
    s_tdata  = sample_t'(1);
    s_tvalid = 1'b1;
    acc_cyc  = cyc;
    @(negedge clk);
    s_tvalid = 1'b0;
    s_tdata  = '0;
    wait_out_valid(VALID_TIMEOUT);
    check_latency(PTAPS * FFT_LEN, cyc - acc_cyc);
    repeat (4 * FFT_LEN) @(negedge clk);  // looped copies keep feeding sums

    // random data, gaps in valid
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rand_bits(16, r);
      s_tdata = sample_t'(r[15:0]);
      rand_bits(3, r);
      s_tvalid = (r[2:0] != 3'd0);  // about 7 in 8
      @(negedge clk);
    end

    // same plus short bursts of en low
    burst   = 0;
    low_cnt = 0;
    for (int i = 0; i < FREEZE_CYCLES; i++) begin
      rand_bits(16, r);
      s_tdata = sample_t'(r[15:0]);
      rand_bits(3, r);
      s_tvalid = (r[2:0] != 3'd0);
      if (burst == 0) begin
        rand_bits(3, r);
        if (r[2:0] == 3'd0) begin
          rand_bits(2, r);
          burst = int'(r[1:0]) + 1;  // 1..4 frozen cycles
        end
      end
      if (burst > 0) begin
        en = 1'b0;
        burst--;
        low_cnt++;
      end else begin
        en = 1'b1;
      end
      @(negedge clk);
    end
    en       = 1'b1;
    s_tvalid = 1'b0;
    repeat (2 * FFT_LEN) @(negedge clk);

    if (low_cnt == 0) begin
      fail_now("no cycles with en low were generated");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
pfb_pkg.sv
delay_buf.sv
pfb_pe.sv
ospfb.sv
ospfb_asserts.sv
tb_ospfb.sv

/* Bender.yml */
package:
  name: ospfb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pfb_pkg.sv
      - delay_buf.sv
      - pfb_pe.sv
      - ospfb.sv
  - target: test
    files:
      - ospfb_asserts.sv
      - tb_ospfb.sv
